//--- build.f
hw/chip_pkg.sv
hw/cmd_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/gpio_block.sv
hw/chip_ctrl.sv
hw/chip_top.sv
verification/tb_checker.sv
verification/tb.sv

//--- hw/chip_ctrl.sv
// Decodes host command bytes into GPIO writes and status replies
// A query arriving while the transmitter is busy is counted but not answered
// Strap status packs NUM_SW_STRAPS strap bits above the command count in one byte
`default_nettype none

module chip_ctrl (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire  [chip_pkg::NUM_SW_STRAPS-1:0] sw_straps_i,
  input  wire  [7:0]                         rx_data_i,
  input  wire                                rx_valid_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0]     gpio_out_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0]     gpio_oe_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0]     gpio_in_i,
  input  wire                                tx_busy_i,
  output logic                               wr_out_o,
  output logic                               wr_oe_o,
  output logic                               wr_hi_o,
  output logic [3:0]                         wr_nib_o,
  output logic                               tx_start_o,
  output logic [7:0]                         tx_data_o
);

  // Count field fills what the straps leave of the status byte
  localparam int CNT_W = 8 - chip_pkg::NUM_SW_STRAPS;

  cmd_pkg::cmd_byte_u cmd;

  logic [chip_pkg::NUM_SW_STRAPS-1:0] straps_q;
  logic [CNT_W-1:0]                   cmd_cnt_q;
  logic [7:0]                         status;
  logic                               is_query;
  logic                               wr_out_q;
  logic                               wr_oe_q;
  logic                               tx_start_q;
  logic                               wr_hi_q;
  logic [3:0]                         wr_nib_q;
  logic [7:0]                         tx_data_q;

  assign cmd      = rx_data_i;
  assign is_query = (cmd.query.op == cmd_pkg::OP_QUERY);

  // Follows the pins for as long as reset is held
  always_ff @(posedge clk_i) begin
    if (reset_i) straps_q <= sw_straps_i;
  end

  // Count is taken before this command's own increment
  always_comb begin
    case (cmd.query.sel)
      cmd_pkg::SEL_GPIO_IN:  status = gpio_in_i;
      cmd_pkg::SEL_GPIO_OUT: status = gpio_out_i;
      cmd_pkg::SEL_GPIO_OE:  status = gpio_oe_i;
      default:               status = {straps_q, cmd_cnt_q};  // SEL_STRAPS
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_out_q   <= 1'b0;
      wr_oe_q    <= 1'b0;
      tx_start_q <= 1'b0;
      cmd_cnt_q  <= '0;
    end else begin
      wr_out_q   <= rx_valid_i && (cmd.wr.op == cmd_pkg::OP_WR_OUT);
      wr_oe_q    <= rx_valid_i && (cmd.wr.op == cmd_pkg::OP_WR_OE);
      tx_start_q <= rx_valid_i && is_query && !tx_busy_i;  // Busy means dropped
      if (rx_valid_i) begin
        cmd_cnt_q <= cmd_cnt_q + 1'b1;  // Every opcode counts, NOP too
      end
    end
  end

  // Payload for the strobes above
  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      wr_hi_q   <= cmd.wr.hi;
      wr_nib_q  <= cmd.wr.nib;
      tx_data_q <= status;
    end
  end

  assign wr_out_o   = wr_out_q;
  assign wr_oe_o    = wr_oe_q;
  assign wr_hi_o    = wr_hi_q;
  assign wr_nib_o   = wr_nib_q;
  assign tx_start_o = tx_start_q;
  assign tx_data_o  = tx_data_q;

endmodule

`default_nettype wire

//--- hw/chip_pkg.sv
// Chip-wide pad and strap counts
// The command set writes GPIOs a nibble at a time, so NUM_GPIOS must stay 8
`default_nettype none

package chip_pkg;

  // GPIO pads, each with separate in, out and enable pins
  parameter int NUM_GPIOS = 8;

  // Software straps, latched while reset is held
  // Reported in the top bits of the strap status byte
  parameter int NUM_SW_STRAPS = 3;

endpackage

`default_nettype wire

//--- hw/chip_top.sv
// Serially controlled GPIO subsystem
// Pads come as separate in, out and enable pins; straps sampled during reset
// Host line runs at clk_i / CLKS_PER_BIT baud, 8N1
`default_nettype none

module chip_top #(
  parameter int CLKS_PER_BIT = 16
) (
  input  wire                                clk_i,
  input  wire                                reset_i,
  input  wire                                uart_rx_i,
  output logic                               uart_tx_o,
  input  wire  [chip_pkg::NUM_SW_STRAPS-1:0] sw_straps_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0]     gpio_i,
  output logic [chip_pkg::NUM_GPIOS-1:0]     gpio_o,
  output logic [chip_pkg::NUM_GPIOS-1:0]     gpio_oe_o
);

  logic [7:0]                     rx_data;
  logic                           rx_valid;
  logic                           wr_out_en;
  logic                           wr_oe_en;
  logic                           wr_hi;
  logic [3:0]                     wr_nib;
  logic                           tx_start;
  logic [7:0]                     tx_data;
  logic                           tx_busy;
  logic [chip_pkg::NUM_GPIOS-1:0] gpio_in_sync;

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .rx_i   (uart_rx_i),
    .data_o (rx_data),
    .valid_o(rx_valid)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_tx (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .start_i(tx_start),
    .data_i (tx_data),
    .tx_o   (uart_tx_o),
    .busy_o (tx_busy)
  );

  gpio_block u_gpio (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .gpio_i        (gpio_i),
    .wr_out_i      (wr_out_en),
    .wr_oe_i       (wr_oe_en),
    .wr_hi_i       (wr_hi),
    .wr_nib_i      (wr_nib),
    .gpio_o        (gpio_o),
    .gpio_oe_o     (gpio_oe_o),
    .gpio_in_sync_o(gpio_in_sync)
  );

  // Register values loop back for status queries
  chip_ctrl u_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sw_straps_i(sw_straps_i),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .gpio_out_i (gpio_o),
    .gpio_oe_i  (gpio_oe_o),
    .gpio_in_i  (gpio_in_sync),
    .tx_busy_i  (tx_busy),
    .wr_out_o   (wr_out_en),
    .wr_oe_o    (wr_oe_en),
    .wr_hi_o    (wr_hi),
    .wr_nib_o   (wr_nib),
    .tx_start_o (tx_start),
    .tx_data_o  (tx_data)
  );

endmodule

`default_nettype wire

//--- hw/cmd_pkg.sv
// Host command byte layout for the serial control link
// The opcode in bits 7:6 decides which view of the byte applies
`default_nettype none

package cmd_pkg;

  typedef enum logic [1:0] {
    OP_WR_OUT = 2'd0,  // Load one nibble of the output register
    OP_WR_OE  = 2'd1,  // Load one nibble of the enable register
    OP_QUERY  = 2'd2,  // Send back one status byte
    OP_NOP    = 2'd3   // Counted only
  } cmd_op_e;

  // Status source picked by a query
  typedef enum logic [1:0] {
    SEL_GPIO_IN  = 2'd0,
    SEL_GPIO_OUT = 2'd1,
    SEL_GPIO_OE  = 2'd2,
    SEL_STRAPS   = 2'd3   // Straps in 7:5, command count in 4:0
  } status_sel_e;

  // Write view
  typedef struct packed {
    cmd_op_e    op;
    logic       hi;    // Upper nibble when set
    logic       rsvd;
    logic [3:0] nib;
  } cmd_wr_t;

  // Query view
  typedef struct packed {
    cmd_op_e     op;
    status_sel_e sel;
    logic [3:0]  rsvd;
  } cmd_query_t;

  typedef union packed {
    cmd_wr_t    wr;
    cmd_query_t query;
  } cmd_byte_u;

endpackage

`default_nettype wire

//--- hw/gpio_block.sv
// GPIO output and enable registers, written one nibble per strobe
// Pad inputs are readable two cycles after they change
`default_nettype none

module gpio_block (
  input  wire                            clk_i,
  input  wire                            reset_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0] gpio_i,
  input  wire                            wr_out_i,
  input  wire                            wr_oe_i,
  input  wire                            wr_hi_i,
  input  wire  [3:0]                     wr_nib_i,
  output logic [chip_pkg::NUM_GPIOS-1:0] gpio_o,
  output logic [chip_pkg::NUM_GPIOS-1:0] gpio_oe_o,
  output logic [chip_pkg::NUM_GPIOS-1:0] gpio_in_sync_o
);

  localparam int HI_BASE = chip_pkg::NUM_GPIOS / 2;

  logic [chip_pkg::NUM_GPIOS-1:0] out_q;
  logic [chip_pkg::NUM_GPIOS-1:0] oe_q;
  logic [chip_pkg::NUM_GPIOS-1:0] in_meta_q;
  logic [chip_pkg::NUM_GPIOS-1:0] in_sync_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      if (wr_out_i && wr_hi_i) out_q[HI_BASE +: 4] <= wr_nib_i;
      if (wr_out_i && !wr_hi_i) out_q[3:0] <= wr_nib_i;
      if (wr_oe_i && wr_hi_i) oe_q[HI_BASE +: 4] <= wr_nib_i;
      if (wr_oe_i && !wr_hi_i) oe_q[3:0] <= wr_nib_i;
    end
  end

  // Pads are asynchronous to clk_i
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_i;
    in_sync_q <= in_meta_q;
  end

  assign gpio_o         = out_q;
  assign gpio_oe_o      = oe_q;
  assign gpio_in_sync_o = in_sync_q;

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
// 8N1 serial receiver, LSB first, idle line high
// CLKS_PER_BIT must be 4 or more; start bit is rechecked at its middle
// valid_o is combinational and lasts the one cycle that samples the stop bit
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        rx_i,
  output logic [7:0] data_o,
  output logic       valid_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic             rx_prev_q;
  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             sample;

  // Two flops into the clock domain, a third for edge detect
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  // Half a bit into the start bit, a full bit for the rest
  assign sample = (state_q == ST_START) ? (cnt_q == HALF_BIT) : (cnt_q == FULL_BIT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
    end else begin
      cnt_q <= sample ? '0 : cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (rx_prev_q && !rx_sync_q) state_q <= ST_START;  // Falling edge
        end
        ST_START: begin
          if (sample) state_q <= rx_sync_q ? ST_IDLE : ST_DATA;  // High again means a glitch
        end
        ST_DATA: begin
          if (sample) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) state_q <= ST_STOP;
          end
        end
        default: begin
          if (sample) state_q <= ST_IDLE;  // Stop bit, good or bad
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_DATA && sample) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

  assign data_o  = shift_q;
  assign valid_o = (state_q == ST_STOP) && sample && rx_sync_q;  // Framing error drops it

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
// 8N1 serial transmitter, one frame per start pulse
// start_i is ignored while busy_o is high
// busy_o falls in the cycle after the stop bit ends
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  wire        clk_i,
  input  wire        reset_i,
  input  wire        start_i,
  input  wire  [7:0] data_i,
  output logic       tx_o,
  output logic       busy_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  logic             busy_q;
  logic [9:0]       frame_q;  // Bit 0 is on the line
  logic [CNT_W-1:0] cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             bit_done;

  assign bit_done = (cnt_q == FULL_BIT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      frame_q   <= '1;  // Line idles high
      cnt_q     <= '0;
      bit_cnt_q <= '0;
    end else if (!busy_q) begin
      cnt_q     <= '0;
      bit_cnt_q <= '0;
      if (start_i) begin
        busy_q  <= 1'b1;
        frame_q <= {1'b1, data_i, 1'b0};  // Stop, data LSB first, start
      end
    end else begin
      cnt_q <= bit_done ? '0 : cnt_q + 1'b1;
      if (bit_done) begin
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0;  // Stop bit done, line stays high
        end else begin
          frame_q   <= {1'b1, frame_q[9:1]};
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  assign tx_o   = frame_q[0];
  assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the chip testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb -f build.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

//--- verification/cmd_input.txt
// First value: software straps in hex, held on sw_straps_i during reset
// Then one command per line: command byte, gpio_i value driven while it is sent
5
80 3c  // first query, gpio inputs
b0 00  // straps and count 1
05 00
2a 00
90 00
09 00  // low nibble only, upper kept
4f 00
63 00
a0 00
c7 00  // NOP
80 a5
1b 00  // reserved bit set
ff 00
6c 00
b0 00
8f 5a  // query with reserved bits set
30 00
40 00
90 00
a0 00
e0 00
27 00
0e 00
51 00
80 ff
90 00
f3 00
62 00
a0 00
80 00
c0 00
b5 00  // count 31
d4 00
b0 00  // count wraps to 1
2d 00
9c 00

//--- verification/tb.sv
// Chip testbench, drives straps, GPIO inputs and host commands from the command file
// The host idles 12 bit times after each byte, so no query finds the transmitter busy
`default_nettype none

module tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_NS       = 100;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam int MEM_WORDS    = 128;

  logic                               clk;
  logic                               reset;
  logic                               rx_line;
  logic                               tx_line;
  logic [chip_pkg::NUM_SW_STRAPS-1:0] sw_straps;
  logic [chip_pkg::NUM_GPIOS-1:0]     gpio_in;
  logic [chip_pkg::NUM_GPIOS-1:0]     gpio_out;
  logic [chip_pkg::NUM_GPIOS-1:0]     gpio_oe;
  int                                 value_errs;
  int                                 other_errs;
  logic                               checker_done;
  logic [15:0]                        stim [MEM_WORDS];
  int                                 n_cmds;

  chip_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) DUT (
    .clk_i      (clk),
    .reset_i    (reset),
    .uart_rx_i  (rx_line),
    .uart_tx_o  (tx_line),
    .sw_straps_i(sw_straps),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .gpio_oe_o  (gpio_oe)
  );

  tb_checker #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .CLK_NS      (CLK_NS)
  ) u_checker (
    .reset_i     (reset),
    .uart_rx_i   (rx_line),
    .uart_tx_i   (tx_line),
    .gpio_out_i  (gpio_out),
    .gpio_oe_i   (gpio_oe),
    .value_errs_o(value_errs),
    .other_errs_o(other_errs),
    .done_o      (checker_done)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // One 8N1 frame, LSB first, then the idle gap
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int k = 0; k < 10; k++) begin
      @(posedge clk);
      #1 rx_line = frame[k];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
    repeat (12 * CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic finish_run(input bit timed_out);
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (!timed_out && value_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  initial begin : stimulus
    clk       = 1'b0;
    reset     = 1'b1;
    rx_line   = 1'b1;
    gpio_in   = '0;
    sw_straps = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      stim[a] = {4'hf, 12'(a)};
    end
    $readmemh("verification/cmd_input.txt", stim);
    n_cmds = 0;
    while (2 * n_cmds + 2 < MEM_WORDS && stim[2 * n_cmds + 1][15:12] != 4'hf) begin
      n_cmds++;
    end
    sw_straps = stim[0][chip_pkg::NUM_SW_STRAPS-1:0];
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    sw_straps = ~stim[0][chip_pkg::NUM_SW_STRAPS-1:0];  // Latch must hold the reset value
    repeat (2 * CLKS_PER_BIT) @(posedge clk);
    for (int i = 0; i < n_cmds; i++) begin
      #1 gpio_in = stim[2 * i + 2][7:0];
      send_byte(stim[2 * i + 1][7:0]);
    end
    wait (checker_done === 1'b1);
    finish_run(1'b0);
  end

  initial begin : watchdog
    int limit_ns;
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    limit_ns = (n_cmds + 2) * 24 * BIT_NS;  // Each command needs 22 bit times
    #(limit_ns);
    $display("Timeout: run did not finish within %0d ns after reset", limit_ns);
    finish_run(1'b1);
  end

endmodule

`default_nettype wire

//--- verification/tb_checker.sv
// Watches the DUT pins and compares them with a model built from the command file
// Assumes one command at a time, with the host line idle long enough for any reply
`default_nettype none

module tb_checker #(
  parameter int CLKS_PER_BIT = 8,
  parameter int CLK_NS       = 100
) (
  input  wire                            reset_i,
  input  wire                            uart_rx_i,
  input  wire                            uart_tx_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0] gpio_out_i,
  input  wire  [chip_pkg::NUM_GPIOS-1:0] gpio_oe_i,
  output int                             value_errs_o,
  output int                             other_errs_o,
  output logic                           done_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BIT_NS    = CLKS_PER_BIT * CLK_NS;
  localparam int MEM_WORDS = 128;

  logic [15:0]                        stim [MEM_WORDS];
  logic [7:0]                         exp_q [$];  // Replies still owed by the DUT
  logic [chip_pkg::NUM_GPIOS-1:0]     exp_out;
  logic [chip_pkg::NUM_GPIOS-1:0]     exp_oe;
  logic [chip_pkg::NUM_SW_STRAPS-1:0] straps;
  int                                 cmd_count;
  int                                 n_cmds;
  int                                 value_errs;
  int                                 other_errs;

  assign value_errs_o = value_errs;
  assign other_errs_o = other_errs;

  task automatic compare_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    other_errs++;
    $display("At %0d ns: %s", $time, msg);
  endtask

  // Status byte as the host should see it, count taken before this command
  function automatic logic [7:0] expected_status(input logic [1:0] sel, input logic [7:0] gin);
    case (sel)
      cmd_pkg::SEL_GPIO_IN:  return gin;
      cmd_pkg::SEL_GPIO_OUT: return exp_out;
      cmd_pkg::SEL_GPIO_OE:  return exp_oe;
      default:               return {straps, 5'(cmd_count % 32)};
    endcase
  endfunction

  initial begin : command_watch
    logic [7:0] cmd;
    logic [7:0] gin;
    for (int a = 0; a < MEM_WORDS; a++) begin
      stim[a] = {4'hf, 12'(a)};  // Marks words the file leaves out
    end
    $readmemh("verification/cmd_input.txt", stim);
    n_cmds = 0;
    while (2 * n_cmds + 2 < MEM_WORDS && stim[2 * n_cmds + 1][15:12] != 4'hf) begin
      n_cmds++;
    end
    straps     = stim[0][chip_pkg::NUM_SW_STRAPS-1:0];
    exp_out    = '0;
    exp_oe     = '0;
    cmd_count  = 0;
    value_errs = 0;
    other_errs = 0;
    done_o     = 1'b0;
    wait (reset_i === 1'b1);
    wait (reset_i === 1'b0);
    #(CLK_NS / 2);
    compare_byte("gpio_o after reset", gpio_out_i, 8'h00);
    compare_byte("gpio_oe_o after reset", gpio_oe_i, 8'h00);
    if (uart_tx_i !== 1'b1) report_failure("uart_tx is not idle high after reset");
    for (int i = 0; i < n_cmds; i++) begin
      @(negedge uart_rx_i);  // Start bit of this command
      if (exp_q.size() != 0) begin
        report_failure($sformatf("reply missing for a query before command %0d", i));
        exp_q.delete();
      end
      cmd = stim[2 * i + 1][7:0];
      gin = stim[2 * i + 2][7:0];
      #(10 * BIT_NS + 20);  // Stop bit is over
      case (cmd[7:6])
        cmd_pkg::OP_WR_OUT: exp_out = cmd[5] ? {cmd[3:0], exp_out[3:0]} : {exp_out[7:4], cmd[3:0]};
        cmd_pkg::OP_WR_OE:  exp_oe  = cmd[5] ? {cmd[3:0], exp_oe[3:0]} : {exp_oe[7:4], cmd[3:0]};
        cmd_pkg::OP_QUERY:  exp_q.push_back(expected_status(cmd[5:4], gin));
        default: ;  // NOP
      endcase
      cmd_count++;
      #(BIT_NS + 20);  // Writes settled by now
      compare_byte($sformatf("gpio_o after command %0d", i), gpio_out_i, exp_out);
      compare_byte($sformatf("gpio_oe_o after command %0d", i), gpio_oe_i, exp_oe);
    end
    #(12 * BIT_NS);
    if (exp_q.size() != 0) report_failure("reply to the last query never arrived");
    done_o = 1'b1;
  end

  // Decodes each frame on uart_tx at its bit middles
  initial begin : reply_watch
    logic [7:0] rx_byte;
    wait (reset_i === 1'b1);
    wait (reset_i === 1'b0);
    forever begin
      @(negedge uart_tx_i);
      #(BIT_NS / 2);
      if (uart_tx_i !== 1'b0) report_failure("reply start bit did not stay low");
      for (int k = 0; k < 8; k++) begin
        #(BIT_NS);
        rx_byte[k] = uart_tx_i;
      end
      #(BIT_NS);
      if (uart_tx_i !== 1'b1) report_failure("reply stop bit is low");
      if (exp_q.size() == 0) begin
        report_failure($sformatf("unexpected reply %02h on uart_tx", rx_byte));
      end else begin
        compare_byte("reply byte", rx_byte, exp_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire
